// File: verilog/proj_pkg.sv
`default_nettype none

package proj_pkg;

	// Q16.15 signed fixed point
	localparam int FX_WIDTH = 32;                     // Word width
	localparam int FX_FRAC  = 15;                     // Fraction bits

	typedef logic signed [FX_WIDTH-1:0] fx_t;         // One Q16.15 word

	localparam fx_t FX_ONE       = 32'sh0000_8000;    // 1.0
	localparam fx_t ASPECT_RATIO = 32'sh0000_6000;    // 240/320 = 0.75
	localparam fx_t HALF_WIDTH   = 32'sh004F_C000;    // 319/2 = 159.5
	localparam fx_t HALF_HEIGHT  = 32'sh003B_C000;    // 239/2 = 119.5
	localparam fx_t DEPTH_Q      = 32'sh0000_8003;    // Far/(far - near)
	localparam fx_t ZNEAR_Q      = 32'sh0000_0CCD;    // Near * q
	localparam fx_t Z_OFFSET     = 32'sh0001_8000;    // Push the model 3.0 into the view

	// Pixel coordinates on the 320x240 screen
	localparam int SCREEN_BITS = 9;
	typedef logic [SCREEN_BITS-1:0] screen_coord_t;

	typedef struct packed
	{
		fx_t x;                                       // World space
		fx_t y;
		fx_t z;
	} world_vertex_t;

	typedef struct packed
	{
		screen_coord_t sx;                            // Column, rounded
		screen_coord_t sy;                            // Row, rounded
		fx_t           depth;                         // Remapped depth
	} screen_vertex_t;

	typedef world_vertex_t  [2:0] world_triangle_t;   // Vertex 0 in the low slot
	typedef screen_vertex_t [2:0] screen_triangle_t;

endpackage

`default_nettype wire

// File: verilog/fx_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module fx_multiplier
	import proj_pkg::*;
(
	input  wire       CLOCK_50,
	input  wire       i_rst_n,
	input  wire       i_start,    // One-cycle pulse, taken while ready
	input  wire fx_t  i_a,        // Magnitude, read LSB first
	input  wire fx_t  i_b,        // Magnitude
	output fx_t       o_product,  // (a * b) >> 15
	output logic      o_ready
);

	logic [2*FX_WIDTH-1:0] acc;       // Sum of partial products
	logic [2*FX_WIDTH-1:0] addend;    // i_b at the weight of the current bit
	logic [FX_WIDTH-1:0]   bits;      // Multiplier bits still to scan
	logic [$clog2(FX_WIDTH):0] count; // 0..32, one extra step gives 33 cycles
	logic                  take;

	assign take = i_start && o_ready;

	// Busy while scanning, ready again after the last step
	always_ff @(posedge CLOCK_50 or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_ready <= 1'b1;                          // Idle out of reset
			count   <= '0;
		end
		else if (take)
		begin
			o_ready <= 1'b0;
			count   <= '0;
		end
		else if (!o_ready)
		begin
			count <= count + 1'b1;
			if (count == FX_WIDTH)
				o_ready <= 1'b1;                      // Product settled
		end
	end

	// Shift-add datapath
	always_ff @(posedge CLOCK_50)
	begin
		if (take)
		begin
			acc    <= '0;
			addend <= {{FX_WIDTH{1'b0}}, i_b};
			bits   <= i_a;
		end
		else if (!o_ready)
		begin
			if (bits[0])
				acc <= acc + addend;                  // Add this weight
			addend <= addend << 1;
			bits   <= bits >> 1;                      // Next multiplier bit into bit 0
		end
	end

	assign o_product = acc[FX_FRAC +: FX_WIDTH];      // Drop the extra fraction bits

endmodule

`default_nettype wire

// File: verilog/fx_divider.sv
`timescale 1ns/1ps
`default_nettype none

module fx_divider
	import proj_pkg::*;
(
	input  wire       CLOCK_50,
	input  wire       i_rst_n,
	input  wire       i_start,     // One-cycle pulse, taken while ready
	input  wire fx_t  i_dividend,  // Magnitude
	input  wire fx_t  i_divisor,   // Magnitude, nonzero
	output fx_t       o_quotient,  // (dividend << 15) / divisor
	output logic      o_ready
);

	logic [FX_WIDTH+FX_FRAC-1:0] num;  // Pre-shifted dividend, MSB first
	logic [FX_WIDTH-1:0]   den;        // Held divisor
	logic [FX_WIDTH-1:0]   rem;        // Partial remainder, always below den
	logic [FX_WIDTH-1:0]   quo;        // Low quotient bits so far
	logic [$clog2(FX_WIDTH+FX_FRAC)-1:0] count; // Bit being decided, 46 down to 0
	logic [FX_WIDTH:0]     trial;      // Remainder with next dividend bit brought down
	logic [FX_WIDTH:0]     diff;
	logic                  q_bit;
	logic                  take;

	assign take  = i_start && o_ready;
	assign trial = {rem, num[FX_WIDTH+FX_FRAC-1]};
	assign diff  = trial - {1'b0, den};
	assign q_bit = (trial >= {1'b0, den});  // Divisor fits, subtract it

	// One quotient bit per cycle under the down-counter
	always_ff @(posedge CLOCK_50 or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_ready <= 1'b1;
			count   <= '0;
		end
		else if (take)
		begin
			o_ready <= 1'b0;
			count   <= 6'(FX_WIDTH + FX_FRAC - 1);
		end
		else if (!o_ready)
		begin
			count <= count - 1'b1;
			if (count == 0)
				o_ready <= 1'b1;                  // Last bit decided this edge
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (take)
		begin
			num <= {i_dividend, {FX_FRAC{1'b0}}}; // Q15 scale before dividing
			den <= i_divisor;
			rem <= '0;
		end
		else if (!o_ready)
		begin
			num <= num << 1;
			rem <= q_bit ? diff[FX_WIDTH-1:0] : trial[FX_WIDTH-1:0]; // Restore when it did not fit
			quo <= {quo[FX_WIDTH-2:0], q_bit};
			if (count == 0)
				o_quotient <= {quo[FX_WIDTH-2:0], q_bit}; // Upper quotient bits fall away
		end
	end

endmodule

`default_nettype wire

// File: verilog/vertex_projector.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_projector
	import proj_pkg::*;
(
	input  wire                 CLOCK_50,
	input  wire                 i_rst_n,
	input  wire                 i_go,      // One-cycle pulse, vertex sampled with it
	input  wire world_vertex_t  i_vertex,
	output screen_vertex_t      o_vertex,  // Valid while o_done is high
	output logic                o_done
);

	typedef enum logic [3:0]
	{
		S_IDLE, S_ABS, S_MUL1_GO, S_MUL1_WAIT, S_NEAR, S_ZCHK, S_DIV_GO, S_DIV_WAIT,
		S_ONE, S_ABS2, S_MUL2_GO, S_MUL2_WAIT, S_ROUND, S_TRUNC, S_DONE
	} state_t;

	state_t     state_q;
	state_t     state_d;
	fx_t        val [3];       // Working x, y and z lanes
	logic [2:0] sgn;           // Sign to restore per lane
	fx_t        zs;            // z + 3.0, the divisor
	fx_t        zs_mag;
	fx_t        mul_b [3];
	fx_t        prod [3];
	fx_t        quot [3];
	logic [2:0] mul_go;
	logic [2:0] mul_rdy;
	logic [2:0] div_rdy;
	logic       div_go;
	logic       scr_phase;     // Screen-scale multiply rather than aspect/depth

	function automatic fx_t fx_abs(input fx_t v);
		return v[FX_WIDTH-1] ? -v : v;
	endfunction

	function automatic fx_t fx_sign(input fx_t mag, input logic neg);
		return neg ? -mag : mag;
	endfunction

	assign zs_mag    = fx_abs(zs);
	assign scr_phase = (state_q == S_MUL2_GO);
	assign div_go    = (state_q == S_DIV_GO);

	always_comb
	begin
		mul_go = 3'b000;
		if (state_q == S_MUL1_GO)
			mul_go = 3'b111;
		else if (scr_phase)
			mul_go = 3'b011;                        // Depth lane is final after the divide
		mul_b[0] = scr_phase ? HALF_WIDTH : ASPECT_RATIO;
		mul_b[1] = scr_phase ? HALF_HEIGHT : FX_ONE; // y passes through unchanged
		mul_b[2] = DEPTH_Q;
	end

	for (genvar i = 0; i < 3; i++)
	begin : g_lane
		fx_multiplier u_mul
		(
			.CLOCK_50  (CLOCK_50),
			.i_rst_n   (i_rst_n),
			.i_start   (mul_go[i]),
			.i_a       (val[i]),
			.i_b       (mul_b[i]),
			.o_product (prod[i]),
			.o_ready   (mul_rdy[i])
		);

		fx_divider u_div
		(
			.CLOCK_50   (CLOCK_50),
			.i_rst_n    (i_rst_n),
			.i_start    (div_go),
			.i_dividend (val[i]),
			.i_divisor  (zs_mag),
			.o_quotient (quot[i]),
			.o_ready    (div_rdy[i])
		);
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			S_IDLE:
				if (i_go)
					state_d = S_ABS;
			S_ABS:       state_d = S_MUL1_GO;
			S_MUL1_GO:   state_d = S_MUL1_WAIT;
			S_MUL1_WAIT:
				if (&mul_rdy)
					state_d = S_NEAR;
			S_NEAR:      state_d = S_ZCHK;
			S_ZCHK:      state_d = (zs == '0) ? S_ONE : S_DIV_GO; // No divide by zero
			S_DIV_GO:    state_d = S_DIV_WAIT;
			S_DIV_WAIT:
				if (&div_rdy)
					state_d = S_ONE;
			S_ONE:       state_d = S_ABS2;
			S_ABS2:      state_d = S_MUL2_GO;
			S_MUL2_GO:   state_d = S_MUL2_WAIT;
			S_MUL2_WAIT:
				if (&mul_rdy)
					state_d = S_ROUND;
			S_ROUND:     state_d = S_TRUNC;
			S_TRUNC:     state_d = S_DONE;
			default:     state_d = S_IDLE;              // Done lasts one cycle
		endcase
	end

	always_ff @(posedge CLOCK_50 or negedge i_rst_n)
	begin
		if (!i_rst_n)
			state_q <= S_IDLE;
		else
			state_q <= state_d;
	end

	// Lane datapath, one step per state
	always_ff @(posedge CLOCK_50)
	begin
		case (state_q)
			S_IDLE:
				if (i_go)
				begin
					val[0] <= i_vertex.x;
					val[1] <= i_vertex.y;
					val[2] <= i_vertex.z + Z_OFFSET;
					zs     <= i_vertex.z + Z_OFFSET;
				end
			S_ABS:
				for (int i = 0; i < 3; i++)
				begin
					sgn[i] <= val[i][FX_WIDTH-1];
					val[i] <= fx_abs(val[i]);       // Units see magnitudes only
				end
			S_MUL1_WAIT:
				if (&mul_rdy)
					for (int i = 0; i < 3; i++)
						val[i] <= fx_sign(prod[i], sgn[i]);
			S_NEAR:
				val[2] <= val[2] - ZNEAR_Q;         // Near-plane term of the depth remap
			S_ZCHK:
				for (int i = 0; i < 3; i++)
				begin
					if (zs == '0)
						val[i] <= '0;               // Vertex on the eye plane
					else
					begin
						sgn[i] <= val[i][FX_WIDTH-1] ^ zs[FX_WIDTH-1];
						val[i] <= fx_abs(val[i]);
					end
				end
			S_DIV_WAIT:
				if (&div_rdy)
					for (int i = 0; i < 3; i++)
						val[i] <= fx_sign(quot[i], sgn[i]);
			S_ONE:
				for (int i = 0; i < 2; i++)
					val[i] <= val[i] + FX_ONE;      // -1..1 becomes 0..2
			S_ABS2:
				for (int i = 0; i < 2; i++)
				begin
					sgn[i] <= val[i][FX_WIDTH-1];
					val[i] <= fx_abs(val[i]);
				end
			S_MUL2_WAIT:
				if (&mul_rdy)
					for (int i = 0; i < 2; i++)
						val[i] <= fx_sign(prod[i], sgn[i]);
			S_ROUND:
				for (int i = 0; i < 2; i++)
					if (val[i][FX_FRAC-1])
						val[i] <= val[i] + FX_ONE;  // Half or more rounds up
			S_TRUNC:
				for (int i = 0; i < 2; i++)
					val[i][FX_FRAC-1:0] <= '0;
			default: ;
		endcase
	end

	always_comb
	begin
		o_vertex.sx    = val[0][FX_FRAC +: SCREEN_BITS]; // Integer part, bits 23:15
		o_vertex.sy    = val[1][FX_FRAC +: SCREEN_BITS];
		o_vertex.depth = val[2];
	end

	assign o_done = (state_q == S_DONE);

endmodule

`default_nettype wire

// File: verilog/triangle_projector.sv
`timescale 1ns/1ps
`default_nettype none

module triangle_projector
	import proj_pkg::*;
(
	input  wire                  CLOCK_50,
	input  wire                  i_rst_n,
	input  wire                  i_start,     // Pulse, ignored while busy
	input  wire world_triangle_t i_triangle,
	output logic                 o_busy,
	output logic                 o_done,      // Level, high once all three vertices are in
	output screen_triangle_t     o_screen     // Held until the next accepted start
);

	world_triangle_t  tri_hold;   // Latched input triangle
	screen_triangle_t res_q;      // Vertices finished so far
	screen_triangle_t res_d;
	screen_triangle_t vtx_out;
	logic [2:0]       vtx_done;
	logic [2:0]       fin_q;      // Per-vertex finished mask
	logic [2:0]       fin_d;
	logic             go_q;       // Go pulse one cycle after the accept
	logic             accept;
	logic             all_fin;

	assign accept  = i_start && !o_busy;
	assign all_fin = o_busy && (&fin_d);

	for (genvar v = 0; v < 3; v++)
	begin : g_vertex
		vertex_projector u_vertex_projector
		(
			.CLOCK_50 (CLOCK_50),
			.i_rst_n  (i_rst_n),
			.i_go     (go_q),
			.i_vertex (tri_hold[v]),
			.o_vertex (vtx_out[v]),
			.o_done   (vtx_done[v])
		);
	end

	// Merge this cycle's done pulses with earlier ones
	always_comb
	begin
		fin_d = fin_q | vtx_done;
		res_d = res_q;
		for (int v = 0; v < 3; v++)
			if (vtx_done[v])
				res_d[v] = vtx_out[v];
	end

	always_ff @(posedge CLOCK_50 or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_busy   <= 1'b0;
			o_done   <= 1'b0;
			o_screen <= '0;
			fin_q    <= '0;
			go_q     <= 1'b0;
		end
		else
		begin
			go_q <= accept;
			if (accept)
			begin
				o_busy <= 1'b1;
				o_done <= 1'b0;
				fin_q  <= '0;
			end
			else if (all_fin)
			begin
				o_busy   <= 1'b0;
				o_done   <= 1'b1;
				o_screen <= res_d;                // Publish all three together
				fin_q    <= '0;
			end
			else if (o_busy)
				fin_q <= fin_d;
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (accept)
			tri_hold <= i_triangle;
		res_q <= res_d;
	end

endmodule

`default_nettype wire

// File: test/tb_projection_tasks.svh
`ifndef TB_PROJECTION_TASKS_SVH
`define TB_PROJECTION_TASKS_SVH

// Linear congruential generator, one step per call
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// Random Q16.15 value from low to low + span
function automatic fx_t rand_range(input int unsigned span, input fx_t low);
	fx_t off;
	off = lcg_next() % (span + 1);
	return low + off;
endfunction

function automatic world_vertex_t make_vertex(input real x, input real y, input real z);
	world_vertex_t v;
	v.x = $rtoi(x * 32768.0);                       // Real to Q16.15
	v.y = $rtoi(y * 32768.0);
	v.z = $rtoi(z * 32768.0);
	return v;
endfunction

// (|a| * |b|) >> 15 on magnitudes, sign restored after
function automatic fx_t mul_ref(input fx_t a, input fx_t b);
	logic [31:0] ma;
	logic [31:0] mb;
	logic [63:0] p;
	fx_t         r;
	ma = a[FX_WIDTH-1] ? -a : a;
	mb = b[FX_WIDTH-1] ? -b : b;
	p  = ({32'd0, ma} * {32'd0, mb}) >> FX_FRAC;
	r  = p[31:0];
	return (a[FX_WIDTH-1] ^ b[FX_WIDTH-1]) ? -r : r;
endfunction

// (|a| << 15) / |b| on magnitudes, truncated toward zero
function automatic fx_t div_ref(input fx_t a, input fx_t b);
	logic [31:0] ma;
	logic [31:0] mb;
	logic [63:0] p;
	fx_t         r;
	ma = a[FX_WIDTH-1] ? -a : a;
	mb = b[FX_WIDTH-1] ? -b : b;
	p  = ({32'd0, ma} << FX_FRAC) / {32'd0, mb};
	r  = p[31:0];
	return (a[FX_WIDTH-1] ^ b[FX_WIDTH-1]) ? -r : r;
endfunction

// Expected screen vertex for one world vertex
function automatic screen_vertex_t project_vertex(input world_vertex_t w);
	fx_t            zs;
	fx_t            px;
	fx_t            pz;
	fx_t            qx;
	fx_t            qy;
	fx_t            qz;
	fx_t            fx;
	fx_t            fy;
	screen_vertex_t s;
	zs = w.z + Z_OFFSET;
	px = mul_ref(w.x, ASPECT_RATIO);
	pz = mul_ref(zs, DEPTH_Q) - ZNEAR_Q;
	qx = 0;                                         // Eye plane gives all zero
	qy = 0;
	qz = 0;
	if (zs != 0)
	begin
		qx = div_ref(px, zs);
		qy = div_ref(w.y, zs);
		qz = div_ref(pz, zs);
	end
	fx = mul_ref(qx + FX_ONE, HALF_WIDTH);
	fy = mul_ref(qy + FX_ONE, HALF_HEIGHT);
	if (fx[FX_FRAC-1])
		fx = fx + FX_ONE;                           // Round half up
	if (fy[FX_FRAC-1])
		fy = fy + FX_ONE;
	fx[FX_FRAC-1:0] = '0;
	fy[FX_FRAC-1:0] = '0;
	s.sx    = fx[FX_FRAC +: SCREEN_BITS];
	s.sy    = fy[FX_FRAC +: SCREEN_BITS];
	s.depth = qz;
	return s;
endfunction

task automatic compare_screen_vertex(input string name, input screen_vertex_t got,
	input screen_vertex_t exp);
	check_count++;
	if (got !== exp)
	begin
		error_count++;
		$display("[FAIL] %s sx=%h sy=%h depth=%h, expected sx=%h sy=%h depth=%h",
			name, got.sx, got.sy, got.depth, exp.sx, exp.sy, exp.depth);
	end
endtask

task automatic compare_busy_done(input string name, input logic got, input logic exp);
	check_count++;
	if (got !== exp)
	begin
		error_count++;
		$display("[FAIL] %s got %h, expected %h", name, got, exp);
	end
endtask

// One start pulse, busy must rise on the next edge
task automatic start_triangle(input world_triangle_t t);
	@(posedge CLOCK_50);
	i_triangle <= t;
	i_start    <= 1'b1;
	@(posedge CLOCK_50);
	i_start <= 1'b0;
	@(negedge CLOCK_50);
	compare_busy_done("o_busy", o_busy, 1'b1);
	compare_busy_done("o_done", o_done, 1'b0);
endtask

// Wait for o_done, then check all three vertices against the model
task automatic check_triangle(input world_triangle_t t);
	while (!o_done)
		@(negedge CLOCK_50);
	compare_busy_done("o_busy", o_busy, 1'b0);      // Busy falls with done
	for (int v = 0; v < 3; v++)
		compare_screen_vertex($sformatf("o_screen[%0d]", v), o_screen[v], project_vertex(t[v]));
endtask

`endif

// File: test/tb_triangle_projector.sv
`timescale 1ns/1ps
`default_nettype none

module tb_triangle_projector
	import proj_pkg::*;
();

	localparam int RUNS           = 10;             // Accepted starts over all tests
	localparam int RUN_CYCLES     = 140;            // Longest vertex path plus margin
	localparam int TIMEOUT_CYCLES = 40 + RUNS * RUN_CYCLES * 3 / 2;

	logic             CLOCK_50;
	logic             i_rst_n;
	logic             i_start;
	world_triangle_t  i_triangle;
	logic             o_busy;
	logic             o_done;
	screen_triangle_t o_screen;

	int          check_count = 0;
	int          error_count = 0;
	int          cycle_count = 0;
	logic [31:0] lcg_state   = 32'haaa;

	`include "tb_projection_tasks.svh"

	triangle_projector u_triangle_projector
	(
		.CLOCK_50   (CLOCK_50),
		.i_rst_n    (i_rst_n),
		.i_start    (i_start),
		.i_triangle (i_triangle),
		.o_busy     (o_busy),
		.o_done     (o_done),
		.o_screen   (o_screen)
	);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #5 CLOCK_50 = ~CLOCK_50;            // 100 MHz in simulation
	end

	// Watchdog
	initial
	begin
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge CLOCK_50);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, o_done never arrived", cycle_count);
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic reset_and_busy();
		world_triangle_t t;
		screen_vertex_t  zero;
		zero = '0;
		@(negedge CLOCK_50);
		compare_busy_done("o_busy", o_busy, 1'b0);  // Idle out of reset
		compare_busy_done("o_done", o_done, 1'b0);
		for (int v = 0; v < 3; v++)
			compare_screen_vertex($sformatf("o_screen[%0d]", v), o_screen[v], zero);
		t[0] = make_vertex(0.5, 0.5, 0.5);
		t[1] = make_vertex(-0.5, 0.25, 1.5);
		t[2] = make_vertex(0.0, -0.75, 2.0);
		start_triangle(t);
		check_triangle(t);
	endtask

	task automatic positive_triangle();
		world_triangle_t t;
		t[0] = make_vertex(1.0, 0.5, 1.0);
		t[1] = make_vertex(0.25, 2.0, 3.5);
		t[2] = make_vertex(2.0, 1.5, 0.5);
		start_triangle(t);
		check_triangle(t);
	endtask

	// Behind the eye with a negative divisor
	task automatic negative_triangle();
		world_triangle_t t;
		t[0] = make_vertex(-1.0, -0.5, -4.0);
		t[1] = make_vertex(-2.5, -1.25, -6.0);
		t[2] = make_vertex(-0.75, -3.0, -3.5);
		start_triangle(t);
		check_triangle(t);
	endtask

	task automatic eye_plane_vertex();
		world_triangle_t t;
		screen_vertex_t  centre;
		t[0] = make_vertex(0.5, 0.5, 1.0);
		t[1] = make_vertex(1.0, -1.0, -3.0);        // z + 3 is zero
		t[2] = make_vertex(-1.5, 0.25, 2.0);
		centre.sx    = 9'd160;
		centre.sy    = 9'd120;
		centre.depth = '0;
		start_triangle(t);
		check_triangle(t);
		compare_screen_vertex("o_screen[1]", o_screen[1], centre);
	endtask

	task automatic start_while_busy();
		world_triangle_t a;
		world_triangle_t b;
		a[0] = make_vertex(0.5, -0.25, 2.0);
		a[1] = make_vertex(-1.0, 1.0, -3.0);        // Skips the divide and finishes early
		a[2] = make_vertex(1.5, 0.75, 4.0);
		b[0] = make_vertex(3.0, 3.0, 3.0);
		b[1] = make_vertex(-3.0, 2.0, 1.0);
		b[2] = make_vertex(2.0, -3.0, 6.0);
		start_triangle(a);
		repeat (100) @(posedge CLOCK_50);           // Vertex 1 is in while the others still run
		i_triangle <= b;                            // Taking it would lose vertex 1
		i_start    <= 1'b1;
		@(posedge CLOCK_50);
		i_start <= 1'b0;
		check_triangle(a);
		repeat (5) @(negedge CLOCK_50);
		compare_busy_done("o_busy", o_busy, 1'b0);  // Nothing queued behind it
		compare_busy_done("o_done", o_done, 1'b1);  // Result held as a level
		for (int v = 0; v < 3; v++)
			compare_screen_vertex($sformatf("o_screen[%0d]", v), o_screen[v],
				project_vertex(a[v]));
	endtask

	task automatic random_triangles();
		world_triangle_t t;
		for (int n = 0; n < 5; n++)
		begin
			for (int v = 0; v < 3; v++)
			begin
				t[v].x = rand_range(32'd262144, -32'sd131072); // -4.0..4.0
				t[v].y = rand_range(32'd262144, -32'sd131072);
				t[v].z = rand_range(32'd262144, 32'sd0);       // 0..8.0
			end
			start_triangle(t);
			check_triangle(t);
		end
	endtask

	initial
	begin
		i_rst_n    = 1'b0;
		i_start    = 1'b0;
		i_triangle = '0;
		repeat (8) @(posedge CLOCK_50);
		i_rst_n <= 1'b1;
		reset_and_busy();
		positive_triangle();
		negative_triangle();
		eye_plane_vertex();
		start_while_busy();
		random_triangles();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: triangle_projector.f
+incdir+test
verilog/proj_pkg.sv
verilog/fx_multiplier.sv
verilog/fx_divider.sv
verilog/vertex_projector.sv
verilog/triangle_projector.sv
test/tb_triangle_projector.sv
